// ==== source/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ****************************************************************************
// Memory geometry
// ****************************************************************************

// Bytes of storage, a power of two so the address wraps by truncation
`define MEM_BYTES 4096

`define MEM_ADDR_BITS 12  // Wrapped byte address

// Data word and processor bus address
`define WORD_BITS 32

`endif

// ==== source/memPkg.sv ====
`default_nettype none

`include "mem_settings.svh"

package memPkg;

    // Data word or full bus address
    typedef logic [`WORD_BITS-1:0] word_t;

    typedef logic [7:0] byte_t;  // One storage cell

    // Byte address after wrap into storage
    typedef logic [`MEM_ADDR_BITS-1:0] byteAddr_t;

    // Lane 0 is the least significant byte of the word
    typedef byteAddr_t [3:0] laneAddrs_t;

endpackage

`default_nettype wire

// ==== source/memPortIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface memPortIf (
    input logic clk
);

    memPkg::word_t addr;    // Byte address, any alignment
    memPkg::word_t wrData;
    logic          wrEn;    // High writes, low reads
    memPkg::word_t rdData;  // Valid one edge after a read

    // Processor side
    modport requester (
        input  clk,
        output addr,
        output wrData,
        output wrEn,
        input  rdData
    );

    modport memory (
        input  clk,
        input  addr,
        input  wrData,
        input  wrEn,
        output rdData
    );

endinterface

`default_nettype wire

// ==== source/carryLookaheadAdder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module carryLookaheadAdder (
    input  memPkg::word_t a,
    input  memPkg::word_t b,
    input  logic          carryIn,
    output memPkg::word_t sum,
    output logic          carryOut
);

    localparam int GROUP_BITS = 4;
    localparam int GROUPS     = `WORD_BITS / GROUP_BITS;

    memPkg::word_t     bitGen;
    memPkg::word_t     bitProp;
    memPkg::word_t     bitCarry;    // Carry into each bit
    logic [GROUPS-1:0] groupGen;
    logic [GROUPS-1:0] groupProp;
    logic [GROUPS:0]   groupCarry;  // Carry into each group

    assign bitGen  = a & b;
    assign bitProp = a ^ b;

    // ************************************************************************
    // First level: group terms, then bit carries inside each group
    // ************************************************************************
    always_comb begin
        logic gen;
        logic prop;
        for (int g = 0; g < GROUPS; g++) begin
            gen  = 1'b0;
            prop = 1'b1;
            for (int i = GROUP_BITS - 1; i >= 0; i--) begin
                gen  = gen | (prop & bitGen[g*GROUP_BITS + i]);
                prop = prop & bitProp[g*GROUP_BITS + i];
            end
            groupGen[g]  = gen;
            groupProp[g] = prop;
        end
    end

    always_comb begin
        logic carry;
        logic prod;
        for (int g = 0; g < GROUPS; g++) begin
            for (int i = 0; i < GROUP_BITS; i++) begin
                carry = 1'b0;
                prod  = 1'b1;
                for (int j = i - 1; j >= 0; j--) begin   // Sum of products, no ripple
                    carry = carry | (prod & bitGen[g*GROUP_BITS + j]);
                    prod  = prod & bitProp[g*GROUP_BITS + j];
                end
                bitCarry[g*GROUP_BITS + i] = carry | (prod & groupCarry[g]);
            end
        end
    end

    // ************************************************************************
    // Second level: group carries straight from carryIn
    // ************************************************************************
    always_comb begin
        logic carry;
        logic prod;
        groupCarry[0] = carryIn;
        for (int g = 0; g < GROUPS; g++) begin
            carry = 1'b0;
            prod  = 1'b1;
            for (int j = g; j >= 0; j--) begin
                carry = carry | (prod & groupGen[j]);
                prod  = prod & groupProp[j];
            end
            groupCarry[g+1] = carry | (prod & carryIn);
        end
    end

    assign sum      = bitProp ^ bitCarry;
    assign carryOut = groupCarry[GROUPS];

    // Lookahead network must agree with plain addition
    always_comb begin
        if (!$isunknown({a, b, carryIn})) begin
            sumCheck: assert final ({carryOut, sum} == {1'b0, a} + {1'b0, b} + 33'(carryIn))
                else $error("Lookahead sum differs from a + b + carryIn");
        end
    end

endmodule

`default_nettype wire

// ==== source/byteAddressUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module byteAddressUnit (
    input  memPkg::word_t      addr,
    output memPkg::laneAddrs_t lanes
);

    memPkg::word_t laneSum [1:3];  // Full 32-bit sums, upper bits dropped

    // One adder per offset lane; lane 0 needs none
    genvar k;
    generate
        for (k = 1; k <= 3; k++) begin : gLaneAdder
            carryLookaheadAdder laneAdder_inst (
                .a        (addr),
                .b        (memPkg::word_t'(k)),
                .carryIn  (1'b0),
                .sum      (laneSum[k]),
                .carryOut ()
            );
        end
    endgenerate

    // Truncation gives the wrap past the last byte
    always_comb begin
        lanes[0] = addr[`MEM_ADDR_BITS-1:0];
        for (int i = 1; i <= 3; i++) begin
            lanes[i] = laneSum[i][`MEM_ADDR_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== source/dualPortMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module dualPortMemory (
    input  logic     clk,
    input  logic     rst,
    memPortIf.memory portA,   // Instruction fetch
    memPortIf.memory portB    // Data, wins on shared writes
);

    memPkg::laneAddrs_t lanesA;
    memPkg::laneAddrs_t lanesB;
    memPkg::byte_t      mem [0:`MEM_BYTES-1];
    memPkg::word_t      rdWordA;
    memPkg::word_t      rdWordB;

    // ************************************************************************
    // Lane address generation
    // ************************************************************************
    byteAddressUnit addrUnitA_inst (
        .addr  (portA.addr),
        .lanes (lanesA)
    );

    byteAddressUnit addrUnitB_inst (
        .addr  (portB.addr),
        .lanes (lanesB)
    );

    // Storage starts cleared
    initial begin
        for (int i = 0; i < `MEM_BYTES; i++) begin
            mem[i] = '0;
        end
    end

    // ************************************************************************
    // Storage writes
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (portA.wrEn) begin
            for (int k = 0; k < 4; k++) begin
                mem[lanesA[k]] <= portA.wrData[8*k +: 8];
            end
        end
        // Applied last so port B keeps a shared byte
        if (portB.wrEn) begin
            for (int k = 0; k < 4; k++) begin
                mem[lanesB[k]] <= portB.wrData[8*k +: 8];
            end
        end
    end

    // Reads sample the array before this edge's writes land
    always_ff @(posedge clk) begin
        if (rst) begin
            rdWordA <= '0;
            rdWordB <= '0;
        end else begin
            if (!portA.wrEn) begin
                for (int k = 0; k < 4; k++) begin
                    rdWordA[8*k +: 8] <= mem[lanesA[k]];  // Lane 0 in bits 7:0
                end
            end
            if (!portB.wrEn) begin
                for (int k = 0; k < 4; k++) begin
                    rdWordB[8*k +: 8] <= mem[lanesB[k]];
                end
            end
        end
    end

    assign portA.rdData = rdWordA;
    assign portB.rdData = rdWordB;

    // Requester strobes and write addresses are known after reset
    wrEnKnownA: assert property (@(posedge clk) disable iff (rst) !$isunknown(portA.wrEn))
        else $error("Port A write strobe unknown");
    wrEnKnownB: assert property (@(posedge clk) disable iff (rst) !$isunknown(portB.wrEn))
        else $error("Port B write strobe unknown");

    wrAddrKnownA: assert property (@(posedge clk) disable iff (rst)
        portA.wrEn |-> !$isunknown(portA.addr))
        else $error("Port A write with unknown address");
    wrAddrKnownB: assert property (@(posedge clk) disable iff (rst)
        portB.wrEn |-> !$isunknown(portB.addr))
        else $error("Port B write with unknown address");

endmodule

`default_nettype wire

// ==== source/memorySubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memorySubsystem (
    input  logic          clk,
    input  logic          rst,

    // Instruction port
    input  memPkg::word_t instrAddr,
    input  memPkg::word_t instrWrData,
    input  logic          instrWrEn,
    output memPkg::word_t instrRdData,

    // Data port
    input  memPkg::word_t dataAddr,
    input  memPkg::word_t dataWrData,
    input  logic          dataWrEn,
    output memPkg::word_t dataRdData
);

    // ************************************************************************
    // Port bundles
    // ************************************************************************
    memPortIf instrIf (
        .clk (clk)
    );

    memPortIf dataIf (
        .clk (clk)
    );

    // Requester side of each bundle
    assign instrIf.addr   = instrAddr;
    assign instrIf.wrData = instrWrData;
    assign instrIf.wrEn   = instrWrEn;
    assign instrRdData    = instrIf.rdData;

    assign dataIf.addr    = dataAddr;
    assign dataIf.wrData  = dataWrData;
    assign dataIf.wrEn    = dataWrEn;
    assign dataRdData     = dataIf.rdData;

    // ************************************************************************
    // Storage
    // ************************************************************************
    dualPortMemory memory_inst (
        .clk   (clk),
        .rst   (rst),
        .portA (instrIf.memory),  // Fetch on A
        .portB (dataIf.memory)    // Loads and stores on B
    );

endmodule

`default_nettype wire

// ==== tests/memorySubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module memorySubsystemTb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 29;
    localparam int RANDOM_CYCLES   = 200;
    localparam int SEED            = 85918;
    localparam int TEST_CYCLES     = RESET_CYCLES + 1 + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int TIMEOUT_NS      = TEST_CYCLES * 2 * CLK_PERIOD;

    logic          clk;
    logic          rst;
    memPkg::word_t instrAddr;
    memPkg::word_t instrWrData;
    logic          instrWrEn;
    memPkg::word_t instrRdData;
    memPkg::word_t dataAddr;
    memPkg::word_t dataWrData;
    logic          dataWrEn;
    memPkg::word_t dataRdData;

    memPkg::byte_t model [0:`MEM_BYTES-1];  // Reference storage
    memPkg::word_t expA;                    // Expected registered read data
    memPkg::word_t expB;
    int            wordErrors;
    int            byteErrors;

    memorySubsystem memorySubsystem_inst (
        .clk         (clk),
        .rst         (rst),
        .instrAddr   (instrAddr),
        .instrWrData (instrWrData),
        .instrWrEn   (instrWrEn),
        .instrRdData (instrRdData),
        .dataAddr    (dataAddr),
        .dataWrData  (dataWrData),
        .dataWrEn    (dataWrEn),
        .dataRdData  (dataRdData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ************************************************************************
    // Reference model and compare tasks
    // ************************************************************************
    function automatic int laneIndex(input memPkg::word_t addr, input int k);
        return (int'(addr % `MEM_BYTES) + k) % `MEM_BYTES;  // Wrap modulo storage size
    endfunction

    function automatic memPkg::word_t modelWord(input memPkg::word_t addr);
        memPkg::word_t w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = model[laneIndex(addr, k)];  // Little endian
        end
        return w;
    endfunction

    task automatic modelWrite(input memPkg::word_t addr, input memPkg::word_t data);
        for (int k = 0; k < 4; k++) begin
            model[laneIndex(addr, k)] = data[8*k +: 8];
        end
    endtask

    task automatic checkWord(input memPkg::word_t actual, input memPkg::word_t expected,
                             input string what);
        if (actual !== expected) begin
            wordErrors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkByte(input memPkg::byte_t actual, input memPkg::byte_t expected,
                             input string what);
        if (actual !== expected) begin
            byteErrors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // One clock of traffic on both ports, driven and checked at falling edges
    task automatic doCycle(input memPkg::word_t aAddr, input memPkg::word_t aData,
                           input logic aWr, input memPkg::word_t bAddr,
                           input memPkg::word_t bData, input logic bWr);
        instrAddr   = aAddr;
        instrWrData = aData;
        instrWrEn   = aWr;
        dataAddr    = bAddr;
        dataWrData  = bData;
        dataWrEn    = bWr;
        if (!aWr) expA = modelWord(aAddr);  // Old contents, before this edge's writes
        if (!bWr) expB = modelWord(bAddr);
        if (aWr) modelWrite(aAddr, aData);
        if (bWr) modelWrite(bAddr, bData);  // Port B last, so it wins
        @(posedge clk);
        @(negedge clk);
        checkWord(instrRdData, expA, "port A read data");
        checkWord(dataRdData, expB, "port B read data");
    endtask

    task automatic readAndCheckBytes(input memPkg::word_t addr);
        doCycle(addr, '0, 1'b0, addr, '0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            checkByte(dataRdData[8*k +: 8], model[laneIndex(addr, k)], "byte lane");
        end
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************
    task automatic testReset();
        checkWord(instrRdData, '0, "port A after reset");
        checkWord(dataRdData, '0, "port B after reset");
        doCycle(32'h000, '0, 1'b0, 32'h100, '0, 1'b0);
        doCycle(32'h800, '0, 1'b0, 32'hFFC, '0, 1'b0);
        doCycle(32'h104, '0, 1'b0, 32'h000, '0, 1'b0);
        doCycle(32'hFFC, '0, 1'b0, 32'h800, '0, 1'b0);
    endtask

    task automatic testAlignedRoundTrip();
        memPkg::word_t addrs [4];
        addrs = '{32'h010, 32'h024, 32'h3F8, 32'hA40};
        for (int i = 0; i < 4; i++) begin
            doCycle(32'h000, '0, 1'b0, addrs[i], 32'h5A00_0000 + 32'(i * 32'h0101_0101), 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            doCycle(addrs[i], '0, 1'b0, addrs[i], '0, 1'b0);
        end
        // Write cycles leave both read registers holding
        doCycle(32'h600, 32'hDEAD_BEEF, 1'b1, 32'h604, 32'hFEED_FACE, 1'b1);
        doCycle(32'h608, 32'h0BAD_F00D, 1'b1, 32'h60C, 32'h1234_5678, 1'b1);
    endtask

    task automatic testUnaligned();
        doCycle(32'h000, '0, 1'b0, 32'h300, 32'h1122_3344, 1'b1);
        doCycle(32'h000, '0, 1'b0, 32'h304, 32'h5566_7788, 1'b1);
        doCycle(32'h000, '0, 1'b0, 32'h301, 32'hA1B2_C3D4, 1'b1);  // Address 4k+1
        doCycle(32'h301, '0, 1'b0, 32'h301, '0, 1'b0);
        checkWord(dataRdData, 32'hA1B2_C3D4, "unaligned word");
        readAndCheckBytes(32'h300);
        checkByte(dataRdData[7:0], 8'h44, "byte below unaligned write");
        checkByte(dataRdData[15:8], 8'hD4, "lowest byte of unaligned write");
        readAndCheckBytes(32'h304);
        checkByte(dataRdData[7:0], 8'hA1, "highest byte of unaligned write");
        checkByte(dataRdData[15:8], 8'h77, "byte above unaligned write");
    endtask

    task automatic testWrap();
        doCycle(32'h000, '0, 1'b0, 32'hFFE, 32'hCAFE_F00D, 1'b1);  // Runs past byte 4095
        readAndCheckBytes(32'h000);
        checkByte(dataRdData[7:0], 8'hFE, "wrapped byte 2");
        checkByte(dataRdData[15:8], 8'hCA, "wrapped byte 3");
        doCycle(32'hFFE, '0, 1'b0, 32'h0001_0FFE, '0, 1'b0);
        checkWord(dataRdData, 32'hCAFE_F00D, "aliased wrap read");
        doCycle(32'h000, '0, 1'b0, 32'h8000_0010, 32'h7654_3210, 1'b1);
        doCycle(32'h010, '0, 1'b0, 32'h010, '0, 1'b0);
        checkWord(instrRdData, 32'h7654_3210, "aliased high address");
    endtask

    task automatic testSameCycle();
        doCycle(32'h400, 32'h1111_1111, 1'b1, 32'h402, 32'h2222_2222, 1'b1);
        readAndCheckBytes(32'h400);
        checkByte(dataRdData[23:16], 8'h22, "shared byte takes port B");
        checkByte(dataRdData[31:24], 8'h22, "shared byte takes port B");
        doCycle(32'h400, '0, 1'b0, 32'h400, 32'h3333_3333, 1'b1);
        checkWord(instrRdData, 32'h2222_1111, "read during other port write");
        doCycle(32'h400, '0, 1'b0, 32'h404, '0, 1'b0);
        checkWord(instrRdData, 32'h3333_3333, "read after other port write");
    endtask

    task automatic testRandomTraffic();
        memPkg::word_t aAddr;
        memPkg::word_t bAddr;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            // Small low window so the ports collide, random upper bits alias
            aAddr = memPkg::word_t'($urandom()) & 32'hFFFF_F03F;
            bAddr = memPkg::word_t'($urandom()) & 32'hFFFF_F03F;
            doCycle(aAddr, memPkg::word_t'($urandom()), 1'($urandom_range(0, 1)),
                    bAddr, memPkg::word_t'($urandom()), 1'($urandom_range(0, 1)));
        end
    endtask

    // ************************************************************************
    // Main sequence and watchdog
    // ************************************************************************
    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        instrAddr   = '0;
        instrWrData = '0;
        instrWrEn   = 1'b0;
        dataAddr    = '0;
        dataWrData  = '0;
        dataWrEn    = 1'b0;
        expA        = '0;
        expB        = '0;
        wordErrors  = 0;
        byteErrors  = 0;
        for (int i = 0; i < `MEM_BYTES; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        testReset();
        testAlignedRoundTrip();
        testUnaligned();
        testWrap();
        testSameCycle();
        testRandomTraffic();

        $display("Word mismatches: %0d, byte mismatches: %0d", wordErrors, byteErrors);
        if (wordErrors + byteErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests did not complete within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/memPkg.sv
source/memPortIf.sv
source/carryLookaheadAdder.sv
source/byteAddressUnit.sv
source/dualPortMemory.sv
source/memorySubsystem.sv
tests/memorySubsystemTb.sv

// ==== Makefile ====
# Verilator build for the dual-port memory testbench

VERILATOR ?= verilator
TOP       ?= memorySubsystemTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
